// ==== hw/core_pkg.sv ====
// Shared stream widths, FIFO sizing, heartbeat timing and FIFO state encoding
package core_pkg;

    // ----------------------------------------------------------------------
    // Stream format of the MAC receive and transmit ports
    // ----------------------------------------------------------------------

    // 64-bit data path for 10G/25G
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;
    localparam int ID_W = 8;

    // Two SFP+ cages
    localparam int CH_CNT = 2;

    // ----------------------------------------------------------------------
    // Frame FIFO sizing
    // ----------------------------------------------------------------------

    // 512 beats of buffer per port
    localparam int FIFO_ADDR_W = 9;

    // Jumbo limit, 9218 bytes in 8-byte beats
    localparam int MAX_FRAME_BEATS = 1153;

    // ----------------------------------------------------------------------
    // Heartbeat
    // ----------------------------------------------------------------------

    // Half period of 0.5 s at 125 MHz
    localparam int HB_COUNT = 62500000;

    // Write side of the frame FIFO
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FRAME,
        WR_DROP
    } fifo_wr_state_t;

endpackage

// ==== hw/heartbeat.sv ====
// Heartbeat divider that toggles a slow blink level from the 125 MHz clock
`timescale 1ns/1ps

module heartbeat #(
    parameter int HB_COUNT = core_pkg::HB_COUNT
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic hb
);

    localparam int CNT_W = $clog2(HB_COUNT);

    logic [CNT_W-1:0] hb_cnt;

    // Down-counter, reload and toggle on zero
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            hb_cnt <= '0;
            hb <= 1'b0;
        end else begin
            if (hb_cnt == '0) begin
                hb_cnt <= CNT_W'(HB_COUNT);
                hb <= !hb;
            end else begin
                hb_cnt <= hb_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== hw/frame_ram.sv ====
// Simple dual-port beat memory with one write port and a registered read port
`timescale 1ns/1ps

module frame_ram #(
    parameter int ADDR_W = 9,
    parameter int WORD_W = 81
) (
    input  logic              clk_125mhz,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds while rd_en is low
    always_ff @(posedge clk_125mhz) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/frame_fifo.sv ====
// Store-and-forward frame FIFO that drops bad, oversize and overflowing frames
`timescale 1ns/1ps

module frame_fifo #(
    parameter int FIFO_ADDR_W = core_pkg::FIFO_ADDR_W,
    parameter int MAX_FRAME_BEATS = core_pkg::MAX_FRAME_BEATS
) (
    input  logic                      clk_125mhz,
    input  logic                      rst_125mhz,

    input  logic [core_pkg::DATA_W-1:0] s_tdata,
    input  logic [core_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                      s_tvalid,
    input  logic                      s_tlast,
    input  logic                      s_tuser,
    input  logic [core_pkg::ID_W-1:0]   s_tid,

    output logic [core_pkg::DATA_W-1:0] m_tdata,
    output logic [core_pkg::KEEP_W-1:0] m_tkeep,
    output logic                      m_tvalid,
    output logic                      m_tlast,
    output logic [core_pkg::ID_W-1:0]   m_tid,
    input  logic                      m_tready,

    output logic                      good_frame,
    output logic                      bad_frame,
    output logic                      overflow
);

    import core_pkg::*;

    localparam int DEPTH = 2**FIFO_ADDR_W;
    localparam int PTR_W = FIFO_ADDR_W + 1;
    localparam int LEN_W = $clog2(MAX_FRAME_BEATS + 1);
    localparam int WORD_W = DATA_W + KEEP_W + ID_W + 1;

    fifo_wr_state_t wr_state;

    // Extra MSB on the pointers tells full from empty
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_commit;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] fill_cnt;
    logic [PTR_W-1:0] commit_cnt;
    logic [LEN_W-1:0] beat_cnt;

    logic full;
    logic oversize;
    logic wr_en;
    logic rd_en;
    logic ram_valid;
    logic out_ready;
    logic mid_ready;

    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;

    // ----------------------------------------------------------------------
    // Write side
    // ----------------------------------------------------------------------

    // Occupancy includes the uncommitted beats of the current frame
    assign fill_cnt = wr_ptr - rd_ptr;
    assign commit_cnt = wr_ptr_commit - rd_ptr;
    assign full = fill_cnt == PTR_W'(DEPTH);
    assign oversize = beat_cnt >= LEN_W'(MAX_FRAME_BEATS);
    assign wr_en = s_tvalid && wr_state != WR_DROP && !full && !oversize;
    assign wr_word = {s_tlast, s_tid, s_tkeep, s_tdata};

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_state <= WR_IDLE;
            wr_ptr <= '0;
            wr_ptr_commit <= '0;
            beat_cnt <= '0;
            good_frame <= 1'b0;
            bad_frame <= 1'b0;
            overflow <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame <= 1'b0;
            overflow <= 1'b0;
            if (s_tvalid) begin
                case (wr_state)
                    WR_IDLE, WR_FRAME: begin
                        if (s_tlast && s_tuser) begin
                            // Bad frame from the MAC
                            wr_ptr <= wr_ptr_commit;
                            beat_cnt <= '0;
                            bad_frame <= 1'b1;
                            wr_state <= WR_IDLE;
                        end else if (full || oversize) begin
                            wr_ptr <= wr_ptr_commit;
                            beat_cnt <= '0;
                            if (s_tlast) begin
                                overflow <= 1'b1;
                                wr_state <= WR_IDLE;
                            end else begin
                                wr_state <= WR_DROP;
                            end
                        end else if (s_tlast) begin
                            // Good frame, make it visible to the read side
                            wr_ptr <= wr_ptr + 1'b1;
                            wr_ptr_commit <= wr_ptr + 1'b1;
                            beat_cnt <= '0;
                            good_frame <= 1'b1;
                            wr_state <= WR_IDLE;
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            beat_cnt <= beat_cnt + 1'b1;
                            wr_state <= WR_FRAME;
                        end
                    end
                    WR_DROP: begin
                        // Discard the rest of the frame
                        if (s_tlast) begin
                            overflow <= 1'b1;
                            wr_state <= WR_IDLE;
                        end
                    end
                    default: begin
                        wr_state <= WR_IDLE;
                    end
                endcase
            end
        end
    end

    frame_ram #(
        .ADDR_W(FIFO_ADDR_W),
        .WORD_W(WORD_W)
    ) i_frame_ram (
        .clk_125mhz(clk_125mhz),
        .wr_en(wr_en),
        .wr_addr(wr_ptr[FIFO_ADDR_W-1:0]),
        .wr_data(wr_word),
        .rd_en(rd_en),
        .rd_addr(rd_ptr[FIFO_ADDR_W-1:0]),
        .rd_data(rd_word)
    );

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------

    // Two stages, RAM output then output register
    assign out_ready = !m_tvalid || m_tready;
    assign mid_ready = !ram_valid || out_ready;
    assign rd_en = rd_ptr != wr_ptr_commit && mid_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            rd_ptr <= '0;
            ram_valid <= 1'b0;
            m_tvalid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (mid_ready) begin
                ram_valid <= rd_en;
            end
            if (out_ready) begin
                m_tvalid <= ram_valid;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (out_ready && ram_valid) begin
            {m_tlast, m_tid, m_tkeep, m_tdata} <= rd_word;
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------

    // Writes land past the committed frames and never wrap onto unread data
    a_no_overwrite: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        wr_en |-> commit_cnt <= fill_cnt && fill_cnt < PTR_W'(DEPTH));

    a_out_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_tid}));

    a_status_onehot: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        $onehot0({good_frame, bad_frame, overflow}));

endmodule

// ==== hw/fpga_core.sv ====
// Loopback core for two SFP+ ports with per-port frame FIFOs and board LEDs
`timescale 1ns/1ps

module fpga_core #(
    parameter int HB_COUNT = core_pkg::HB_COUNT,
    parameter int FIFO_ADDR_W = core_pkg::FIFO_ADDR_W,
    parameter int MAX_FRAME_BEATS = core_pkg::MAX_FRAME_BEATS
) (
    input  logic clk_125mhz,
    input  logic rst_125mhz,

    // MAC receive streams
    input  logic [core_pkg::DATA_W-1:0] rx_tdata [core_pkg::CH_CNT],
    input  logic [core_pkg::KEEP_W-1:0] rx_tkeep [core_pkg::CH_CNT],
    input  logic rx_tvalid [core_pkg::CH_CNT],
    input  logic rx_tlast [core_pkg::CH_CNT],
    input  logic rx_tuser [core_pkg::CH_CNT],
    input  logic [core_pkg::ID_W-1:0] rx_tid [core_pkg::CH_CNT],

    // MAC transmit streams
    output logic [core_pkg::DATA_W-1:0] tx_tdata [core_pkg::CH_CNT],
    output logic [core_pkg::KEEP_W-1:0] tx_tkeep [core_pkg::CH_CNT],
    output logic tx_tvalid [core_pkg::CH_CNT],
    output logic tx_tlast [core_pkg::CH_CNT],
    output logic [core_pkg::ID_W-1:0] tx_tid [core_pkg::CH_CNT],
    input  logic tx_tready [core_pkg::CH_CNT],

    input  logic rx_status [core_pkg::CH_CNT],

    output logic good_frame [core_pkg::CH_CNT],
    output logic bad_frame [core_pkg::CH_CNT],
    output logic overflow [core_pkg::CH_CNT],

    // Board LEDs, lit when low
    output logic sfp_led [core_pkg::CH_CNT],
    output logic [3:0] led,
    output logic led_r,
    output logic led_g,
    output logic led_hb
);

    import core_pkg::*;

    logic hb;

    heartbeat #(
        .HB_COUNT(HB_COUNT)
    ) i_heartbeat (
        .clk_125mhz(clk_125mhz),
        .rst_125mhz(rst_125mhz),
        .hb(hb)
    );

    assign led_hb = !hb;
    assign led = '1;
    assign led_r = 1'b1;
    assign led_g = 1'b1;

    for (genvar n = 0; n < CH_CNT; n++) begin : sfp_ch
        assign sfp_led[n] = !rx_status[n];

        // Receive of port n loops back to transmit of port n
        frame_fifo #(
            .FIFO_ADDR_W(FIFO_ADDR_W),
            .MAX_FRAME_BEATS(MAX_FRAME_BEATS)
        ) i_frame_fifo (
            .clk_125mhz(clk_125mhz),
            .rst_125mhz(rst_125mhz),
            .s_tdata(rx_tdata[n]),
            .s_tkeep(rx_tkeep[n]),
            .s_tvalid(rx_tvalid[n]),
            .s_tlast(rx_tlast[n]),
            .s_tuser(rx_tuser[n]),
            .s_tid(rx_tid[n]),
            .m_tdata(tx_tdata[n]),
            .m_tkeep(tx_tkeep[n]),
            .m_tvalid(tx_tvalid[n]),
            .m_tlast(tx_tlast[n]),
            .m_tid(tx_tid[n]),
            .m_tready(tx_tready[n]),
            .good_frame(good_frame[n]),
            .bad_frame(bad_frame[n]),
            .overflow(overflow[n])
        );
    end

endmodule

// ==== verification/tb_fpga_core.sv ====
// Testbench for the two-port loopback core with frame scoreboard and LED checks
`timescale 1ns/1ps

module tb_fpga_core;

    import core_pkg::*;

    localparam int FIFO_AW = 4;
    localparam int MAX_BEATS = 8;
    localparam int DEPTH = 2**FIFO_AW;
    localparam int BEAT_W = DATA_W + KEEP_W + ID_W + 1;
    localparam int TIMEOUT = 2000;

    logic clk_125mhz = 1'b0;
    logic rst_125mhz = 1'b1;
    logic [DATA_W-1:0] rx_tdata [CH_CNT];
    logic [KEEP_W-1:0] rx_tkeep [CH_CNT];
    logic rx_tvalid [CH_CNT];
    logic rx_tlast [CH_CNT];
    logic rx_tuser [CH_CNT];
    logic [ID_W-1:0] rx_tid [CH_CNT];
    logic [DATA_W-1:0] tx_tdata [CH_CNT];
    logic [KEEP_W-1:0] tx_tkeep [CH_CNT];
    logic tx_tvalid [CH_CNT];
    logic tx_tlast [CH_CNT];
    logic [ID_W-1:0] tx_tid [CH_CNT];
    logic tx_tready [CH_CNT];
    logic rx_status [CH_CNT];
    logic good_frame [CH_CNT];
    logic bad_frame [CH_CNT];
    logic overflow [CH_CNT];
    logic sfp_led [CH_CNT];
    logic [3:0] led;
    logic led_r;
    logic led_g;
    logic led_hb;

    // Scoreboard state
    logic [BEAT_W-1:0] exp_q [CH_CNT][$];
    logic [BEAT_W-1:0] head [CH_CNT];
    logic head_ok [CH_CNT];
    logic [2:0] exp_stat [CH_CNT];
    logic [2:0] exp_stat_q [CH_CNT];

    // Heartbeat tracking
    logic hb_last;
    logic hb_armed;
    int hb_gap;

    always #4 clk_125mhz = !clk_125mhz;

    fpga_core #(
        .HB_COUNT(20),
        .FIFO_ADDR_W(FIFO_AW),
        .MAX_FRAME_BEATS(MAX_BEATS)
    ) i_dut (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // ----------------------------------------------------------------------
    // Reference models clocked alongside the DUT
    // ----------------------------------------------------------------------

    always @(posedge clk_125mhz) begin
        for (int n = 0; n < CH_CNT; n++) begin
            if (tx_tvalid[n] && tx_tready[n] && exp_q[n].size() > 0) begin
                void'(exp_q[n].pop_front());
            end
            head_ok[n] <= exp_q[n].size() > 0;
            head[n] <= exp_q[n].size() > 0 ? exp_q[n][0] : '0;
            exp_stat_q[n] <= (rx_tvalid[n] && rx_tlast[n]) ? exp_stat[n] : 3'b000;
        end
        if (rst_125mhz) begin
            hb_gap <= 0;
            hb_armed <= 1'b0;
        end else if (led_hb != hb_last) begin
            hb_gap <= 0;
            hb_armed <= 1'b1;
        end else begin
            hb_gap <= hb_gap + 1;
        end
        hb_last <= led_hb;
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------

    for (genvar g = 0; g < CH_CNT; g++) begin : chk
        a_tx_beat: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
            tx_tvalid[g] && tx_tready[g] |->
                head_ok[g] && {tx_tlast[g], tx_tid[g], tx_tkeep[g], tx_tdata[g]} == head[g])
            else fail_run($sformatf("CHECK FAILED t=%0t tx_beat[%0d] got %h exp %h ok %b",
                $time, g, {tx_tlast[g], tx_tid[g], tx_tkeep[g], tx_tdata[g]},
                head[g], head_ok[g]));

        a_status: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
            {good_frame[g], bad_frame[g], overflow[g]} == exp_stat_q[g])
            else fail_run($sformatf("CHECK FAILED t=%0t status[%0d] got %b exp %b",
                $time, g, {good_frame[g], bad_frame[g], overflow[g]}, exp_stat_q[g]));

        a_sfp_led: assert property (@(posedge clk_125mhz) sfp_led[g] == !rx_status[g])
            else fail_run($sformatf("CHECK FAILED t=%0t sfp_led[%0d] got %b exp %b",
                $time, g, sfp_led[g], !rx_status[g]));
    end

    a_fixed_led: assert property (@(posedge clk_125mhz) {led, led_r, led_g} == 6'h3f)
        else fail_run($sformatf("CHECK FAILED t=%0t led got %h exp %h",
            $time, {led, led_r, led_g}, 6'h3f));

    a_hb_reset: assert property (@(posedge clk_125mhz) rst_125mhz |=> led_hb)
        else fail_run($sformatf("CHECK FAILED t=%0t led_hb got %b exp %b",
            $time, led_hb, 1'b1));

    a_hb_period: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        hb_armed && led_hb != hb_last |-> hb_gap == 20)
        else fail_run($sformatf("CHECK FAILED t=%0t led_hb_period got %0d exp %0d",
            $time, hb_gap + 1, 21));

    // A stuck heartbeat never reaches the period check above
    a_hb_alive: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        hb_gap <= 20)
        else fail_run($sformatf("led_hb did not toggle within 21 cycles at t=%0t", $time));

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    // Sends one frame and queues the beats of a kept frame with its status
    task automatic send_frame(input int p, input int len, input bit bad, input bit kept);
        logic [BEAT_W-1:0] beats [$];
        logic [31:0] rnd;
        for (int i = 0; i < len; i++) begin
            @(negedge clk_125mhz);
            rnd = $urandom();
            rx_tdata[p] = {$urandom(), $urandom()};
            rx_tkeep[p] = rnd[7:0];
            rx_tid[p] = rnd[15:8];
            rx_tvalid[p] = 1'b1;
            rx_tlast[p] = i == len - 1;
            rx_tuser[p] = bad && i == len - 1;
            rx_status[p] = rnd[16];
            beats.push_back({rx_tlast[p], rx_tid[p], rx_tkeep[p], rx_tdata[p]});
        end
        exp_stat[p] = bad ? 3'b010 : (kept ? 3'b100 : 3'b001);
        if (kept) begin
            foreach (beats[i]) exp_q[p].push_back(beats[i]);
        end
        @(negedge clk_125mhz);
        rx_tvalid[p] = 1'b0;
        rx_tlast[p] = 1'b0;
        rx_tuser[p] = 1'b0;
    endtask

    // Holds back a frame until the FIFO has room for all of it
    task automatic wait_space(input int p, input int len);
        int cnt;
        cnt = 0;
        while (exp_q[p].size() + len > DEPTH) begin
            @(negedge clk_125mhz);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_run($sformatf("Timeout waiting for FIFO space on port %0d", p));
            end
        end
    endtask

    task automatic wait_tx_valid(input int p);
        int cnt;
        cnt = 0;
        while (!tx_tvalid[p]) begin
            @(negedge clk_125mhz);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_run($sformatf("Timeout waiting for a tx beat on port %0d", p));
            end
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
            @(negedge clk_125mhz);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_run("Timeout waiting for expected frames on tx");
            end
        end
    endtask

    task automatic random_frames(input int p, input int count);
        int len;
        for (int f = 0; f < count; f++) begin
            len = 1 + int'($urandom_range(MAX_BEATS - 1));
            wait_space(p, len);
            send_frame(p, len, 1'b0, 1'b1);
        end
    endtask

    task automatic random_ready(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk_125mhz);
            tx_tready[0] = $urandom_range(1) == 1;
            tx_tready[1] = $urandom_range(1) == 1;
        end
    endtask

    initial begin
        void'($urandom(32'h53352f5f));
        for (int n = 0; n < CH_CNT; n++) begin
            rx_tdata[n] = '0;
            rx_tkeep[n] = '0;
            rx_tvalid[n] = 1'b0;
            rx_tlast[n] = 1'b0;
            rx_tuser[n] = 1'b0;
            rx_tid[n] = '0;
            tx_tready[n] = 1'b1;
            rx_status[n] = 1'b0;
            exp_stat[n] = 3'b000;
        end
        repeat (2) @(negedge clk_125mhz);
        rst_125mhz = 1'b0;

        // Good frames on both ports followed by bad and oversize frames among good ones
        fork
            random_frames(0, 12);
            random_frames(1, 12);
        join
        send_frame(0, 3, 1'b1, 1'b0);
        send_frame(0, 2, 1'b0, 1'b1);
        send_frame(1, MAX_BEATS + 1, 1'b0, 1'b0);
        send_frame(1, MAX_BEATS, 1'b0, 1'b1);
        wait_drain();

        // Stall port 0 with two beats in the output stages and 14 in the RAM
        @(negedge clk_125mhz);
        tx_tready[0] = 1'b0;
        send_frame(0, 4, 1'b0, 1'b1);
        wait_tx_valid(0);
        for (int f = 0; f < 4; f++) send_frame(0, 4, 1'b0, f < 3);
        send_frame(0, 4, 1'b0, 1'b0);
        repeat (5) @(negedge clk_125mhz);
        tx_tready[0] = 1'b1;
        wait_drain();

        // Random back-pressure on both ports
        fork
            random_frames(0, 20);
            random_frames(1, 20);
            random_ready(600);
        join
        @(negedge clk_125mhz);
        tx_tready[0] = 1'b1;
        tx_tready[1] = 1'b1;
        wait_drain();
        repeat (50) @(negedge clk_125mhz);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/core_pkg.sv
hw/heartbeat.sv
hw/frame_ram.sv
hw/frame_fifo.sv
hw/fpga_core.sv
verification/tb_fpga_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback core simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_fpga_core \
    -o sim_tb_fpga_core

# The simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/sim_tb_fpga_core > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    exit 1
fi
exit 0
